//--- include/mem_map.svh
`ifndef MEM_MAP_SVH
`define MEM_MAP_SVH

`define MEM_MAP_CLINT_START     64'h0000_0000_0200_0000
`define MEM_MAP_CLINT_END       64'h0000_0000_0200_ffff

`define MEM_MAP_UART_START      64'h0000_0000_1000_0000
`define MEM_MAP_UART_END        64'h0000_0000_1000_0fff

`define MEM_MAP_SPICTRL_START   64'h0000_0000_1000_1000
`define MEM_MAP_SPICTRL_END     64'h0000_0000_1000_1fff

`define MEM_MAP_SPI_START       64'h0000_0000_3000_0000
`define MEM_MAP_SPI_END         64'h0000_0000_3fff_ffff

`define MEM_MAP_CHIPLINK_START  64'h0000_0000_4000_0000
`define MEM_MAP_CHIPLINK_END    64'h0000_0000_7fff_ffff

`endif

//--- hdl/mem_pkg.sv
`include "mem_map.svh"

package mem_pkg;

    typedef enum logic [2:0] {
        SZ_BYTE   = 3'd0,
        SZ_HALF   = 3'd1,
        SZ_WORD   = 3'd2,
        SZ_DOUBLE = 3'd3
    } access_size_e;

    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [63:0]      d;
    } data_lanes_u;

    function automatic logic is_device_addr(input logic [63:0] addr);
        logic hit;
        hit = ((addr >= `MEM_MAP_CLINT_START)    && (addr <= `MEM_MAP_CLINT_END))    |
              ((addr >= `MEM_MAP_UART_START)     && (addr <= `MEM_MAP_UART_END))     |
              ((addr >= `MEM_MAP_SPICTRL_START)  && (addr <= `MEM_MAP_SPICTRL_END))  |
              ((addr >= `MEM_MAP_SPI_START)      && (addr <= `MEM_MAP_SPI_END))      |
              ((addr >= `MEM_MAP_CHIPLINK_START) && (addr <= `MEM_MAP_CHIPLINK_END));
        return hit;
    endfunction

    function automatic logic [7:0] lane_sel(input access_size_e size, input logic [2:0] off);
        logic [7:0] sel;
        case (size)
            SZ_BYTE: sel = 8'b0000_0001 << off;
            SZ_HALF: sel = 8'b0000_0011 << {off[2:1], 1'b0};
            SZ_WORD: sel = 8'b0000_1111 << {off[2], 2'b00};
            default: sel = 8'hff;
        endcase
        return sel;
    endfunction

    function automatic logic [63:0] align_addr(input access_size_e size, input logic [63:0] addr);
        logic [63:0] aligned;
        case (size)
            SZ_BYTE: aligned = addr;
            SZ_HALF: aligned = {addr[63:1], 1'b0};
            SZ_WORD: aligned = {addr[63:2], 2'b00};
            default: aligned = {addr[63:3], 3'b000};
        endcase
        return aligned;
    endfunction

    // store data moved from the low end into its lane.
    function automatic data_lanes_u insert_lanes(input access_size_e size, input logic [2:0] off,
                                                 input logic [63:0] data);
        data_lanes_u lanes;
        lanes.d = '0;
        case (size)
            SZ_BYTE: lanes.b[off]      = data[7:0];
            SZ_HALF: lanes.h[off[2:1]] = data[15:0];
            SZ_WORD: lanes.w[off[2]]   = data[31:0];
            default: lanes.d           = data;
        endcase
        return lanes;
    endfunction

    function automatic logic [63:0] extract_lanes(input access_size_e size, input logic [2:0] off,
                                                  input data_lanes_u lanes);
        logic [63:0] result;
        case (size)
            SZ_BYTE: result = {56'b0, lanes.b[off]};
            SZ_HALF: result = {48'b0, lanes.h[off[2:1]]};
            SZ_WORD: result = {32'b0, lanes.w[off[2]]};
            default: result = lanes.d;
        endcase
        return result;
    endfunction

endpackage

//--- hdl/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if;

    logic                  stb;
    logic                  we;
    logic [63:0]           adr;
    mem_pkg::access_size_e size;
    logic [63:0]           wdata;
    logic [63:0]           rdata;
    logic                  ack;  // one cycle pulse.

    modport requester (
        output stb,
        output we,
        output adr,
        output size,
        output wdata,
        input  rdata,
        input  ack
    );

    modport responder (
        input  stb,
        input  we,
        input  adr,
        input  size,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

//--- hdl/uncache_router.sv
`timescale 1ns/1ps

module uncache_router (
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  core_cyc,
    input  logic                  core_stb,
    input  logic                  core_we,
    input  logic [63:0]           core_adr,
    input  mem_pkg::access_size_e core_size,
    input  logic [63:0]           core_wdata,
    output logic [63:0]           core_rdata,
    output logic                  core_ack,

    mem_req_if.requester          cache_req,
    mem_req_if.requester          mmio_req
);

    logic active;
    logic device;

    assign active = core_cyc && core_stb;
    assign device = mem_pkg::is_device_addr(core_adr);

    // only one side ever sees the strobe.
    assign cache_req.stb   = active && !device;
    assign mmio_req.stb    = active && device;

    assign cache_req.we    = core_we;
    assign cache_req.adr   = core_adr;
    assign cache_req.size  = core_size;
    assign cache_req.wdata = core_wdata;

    assign mmio_req.we     = core_we;
    assign mmio_req.adr    = core_adr;
    assign mmio_req.size   = core_size;
    assign mmio_req.wdata  = core_wdata;

    // address is held until ack, so the select is stable.
    assign core_ack   = device ? mmio_req.ack   : cache_req.ack;
    assign core_rdata = device ? mmio_req.rdata : cache_req.rdata;

    // a side never answers a request the core did not make.
    a_ack_needs_stb: assert property (
        @(posedge clk) disable iff (!arst_n)
        core_ack |-> core_stb
    );

    // one request in flight, so one reply at a time.
    a_one_side: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(cache_req.ack && mmio_req.ack)
    );

endmodule

//--- hdl/dcache_lite.sv
`timescale 1ns/1ps

module dcache_lite #(
    parameter int RAM_DEPTH_LOG2  = 10,
    parameter int LINE_COUNT_LOG2 = 4
) (
    input  logic          clk,
    input  logic          arst_n,
    mem_req_if.responder  req
);

    localparam int RAM_DEPTH  = 1 << RAM_DEPTH_LOG2;
    localparam int LINE_COUNT = 1 << LINE_COUNT_LOG2;
    localparam int TAG_W      = RAM_DEPTH_LOG2 - LINE_COUNT_LOG2;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_FILL  = 2'd1;
    localparam logic [1:0] S_REPLY = 2'd2;

    logic [1:0]                 state;
    logic                       ack_q;
    logic [63:0]                rdata_q;
    logic [LINE_COUNT-1:0]      valid;
    logic [TAG_W-1:0]           tag_mem [LINE_COUNT];
    logic [63:0]                line_data [LINE_COUNT];
    logic [63:0]                ram [RAM_DEPTH];
    logic [63:0]                ram_q;

    logic [63:0]                addr;
    logic [RAM_DEPTH_LOG2-1:0]  word_idx;
    logic [LINE_COUNT_LOG2-1:0] line_idx;
    logic [TAG_W-1:0]           tag;
    logic                       hit;
    logic                       accept;
    logic [7:0]                 sel;
    mem_pkg::data_lanes_u       wlanes;

    function automatic logic [63:0] merge_bytes(input mem_pkg::data_lanes_u old_d,
                                                input mem_pkg::data_lanes_u new_d,
                                                input logic [7:0] be);
        mem_pkg::data_lanes_u merged;
        for (int i = 0; i < 8; i++) begin
            merged.b[i] = be[i] ? new_d.b[i] : old_d.b[i];
        end
        return merged.d;
    endfunction

    assign addr     = mem_pkg::align_addr(req.size, req.adr);
    assign word_idx = addr[3 +: RAM_DEPTH_LOG2];    // wraps modulo depth.
    assign line_idx = addr[3 +: LINE_COUNT_LOG2];
    assign tag      = addr[3 + LINE_COUNT_LOG2 +: TAG_W];
    assign hit      = valid[line_idx] && (tag_mem[line_idx] == tag);
    assign sel      = mem_pkg::lane_sel(req.size, addr[2:0]);
    assign wlanes   = mem_pkg::insert_lanes(req.size, addr[2:0], req.wdata);

    // ack_q masks the request still on the bus in the ack cycle.
    assign accept   = (state == S_IDLE) && req.stb && !ack_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            ack_q <= 1'b0;
            valid <= '0;
        end else begin
            ack_q <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        if (req.we || hit) begin
                            ack_q <= 1'b1;
                        end else begin
                            state <= S_FILL;
                        end
                    end
                end
                S_FILL: begin
                    valid[line_idx] <= 1'b1;
                    state           <= S_REPLY;
                end
                S_REPLY: begin
                    ack_q <= 1'b1;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (accept) begin
                    ram_q <= ram[word_idx];
                    if (req.we) begin
                        ram[word_idx] <= merge_bytes(ram[word_idx], wlanes, sel);  // write-through.
                        if (hit) begin
                            line_data[line_idx] <= merge_bytes(line_data[line_idx], wlanes, sel);
                        end
                    end else if (hit) begin
                        rdata_q <= mem_pkg::extract_lanes(req.size, addr[2:0],
                                                          line_data[line_idx]);
                    end
                end
            end
            S_FILL: begin
                line_data[line_idx] <= ram_q;
                tag_mem[line_idx]   <= tag;
            end
            S_REPLY: begin
                rdata_q <= mem_pkg::extract_lanes(req.size, addr[2:0], line_data[line_idx]);
            end
            default: ;
        endcase
    end

    assign req.ack   = ack_q;
    assign req.rdata = rdata_q;

    a_ack_single: assert property (
        @(posedge clk) disable iff (!arst_n)
        req.ack |=> !req.ack
    );

endmodule

//--- hdl/mmio_bridge.sv
`timescale 1ns/1ps

module mmio_bridge (
    input  logic          clk,
    input  logic          arst_n,
    mem_req_if.responder  req,

    output logic          pb_cyc,
    output logic          pb_stb,
    output logic          pb_we,
    output logic [63:0]   pb_adr,
    output logic [7:0]    pb_sel,
    output logic [63:0]   pb_wdata,
    input  logic [63:0]   pb_rdata,
    input  logic          pb_ack
);

    logic                  bus_q;
    logic                  ack_q;
    logic [63:0]           rdata_q;
    mem_pkg::access_size_e size_q;
    logic [2:0]            off_q;
    logic [63:0]           addr;
    logic                  accept;
    mem_pkg::data_lanes_u  wlanes;

    assign addr   = mem_pkg::align_addr(req.size, req.adr);
    assign wlanes = mem_pkg::insert_lanes(req.size, addr[2:0], req.wdata);
    assign accept = !bus_q && req.stb && !ack_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_q <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            if (accept) begin
                bus_q <= 1'b1;
            end else if (bus_q && pb_ack) begin
                bus_q <= 1'b0;
                ack_q <= 1'b1;                          // core sees ack one cycle later.
            end
        end
    end

    // request fields latched once, held through any stall.
    always_ff @(posedge clk) begin
        if (accept) begin
            pb_adr   <= {addr[63:3], 3'b000};
            pb_sel   <= mem_pkg::lane_sel(req.size, addr[2:0]);
            pb_we    <= req.we;
            pb_wdata <= wlanes.d;
            size_q   <= req.size;
            off_q    <= addr[2:0];
        end
        if (bus_q && pb_ack) begin
            rdata_q <= pb_we ? 64'b0 : mem_pkg::extract_lanes(size_q, off_q, pb_rdata);
        end
    end

    assign pb_cyc    = bus_q;
    assign pb_stb    = bus_q;
    assign req.ack   = ack_q;
    assign req.rdata = rdata_q;

    a_pb_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        (pb_stb && !pb_ack) |=> (pb_stb && $stable({pb_adr, pb_sel, pb_we}))
    );

endmodule

//--- hdl/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int RAM_DEPTH_LOG2  = 10,
    parameter int LINE_COUNT_LOG2 = 4
) (
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  core_cyc,
    input  logic                  core_stb,
    input  logic                  core_we,
    input  logic [63:0]           core_adr,
    input  mem_pkg::access_size_e core_size,
    input  logic [63:0]           core_wdata,
    output logic [63:0]           core_rdata,
    output logic                  core_ack,

    output logic                  pb_cyc,
    output logic                  pb_stb,
    output logic                  pb_we,
    output logic [63:0]           pb_adr,
    output logic [7:0]            pb_sel,
    output logic [63:0]           pb_wdata,
    input  logic [63:0]           pb_rdata,
    input  logic                  pb_ack
);

    mem_req_if cache_req ();
    mem_req_if mmio_req ();

    uncache_router u_router (
        .clk        (clk),
        .arst_n     (arst_n),
        .core_cyc   (core_cyc),
        .core_stb   (core_stb),
        .core_we    (core_we),
        .core_adr   (core_adr),
        .core_size  (core_size),
        .core_wdata (core_wdata),
        .core_rdata (core_rdata),
        .core_ack   (core_ack),
        .cache_req  (cache_req.requester),
        .mmio_req   (mmio_req.requester)
    );

    dcache_lite #(
        .RAM_DEPTH_LOG2  (RAM_DEPTH_LOG2),
        .LINE_COUNT_LOG2 (LINE_COUNT_LOG2)
    ) u_dcache (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (cache_req.responder)
    );

    mmio_bridge u_mmio (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (mmio_req.responder),
        .pb_cyc   (pb_cyc),
        .pb_stb   (pb_stb),
        .pb_we    (pb_we),
        .pb_adr   (pb_adr),
        .pb_sel   (pb_sel),
        .pb_wdata (pb_wdata),
        .pb_rdata (pb_rdata),
        .pb_ack   (pb_ack)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter realtime PERIOD = 40ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

//--- test/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int RAM_DEPTH_LOG2  = 10;
    localparam int LINE_COUNT_LOG2 = 4;
    localparam int RAM_DEPTH       = 1 << RAM_DEPTH_LOG2;
    localparam int LINE_COUNT      = 1 << LINE_COUNT_LOG2;
    localparam int MAX_CYCLES      = 5000;  // 400 transfers at about 10 cycles.

    logic clk, arst_n;
    logic core_cyc, core_stb, core_we;
    logic [63:0] core_adr, core_wdata, core_rdata;
    mem_pkg::access_size_e core_size;
    logic core_ack;
    logic pb_cyc, pb_stb, pb_we, pb_ack;
    logic [63:0] pb_adr, pb_wdata, pb_rdata;
    logic [7:0] pb_sel;

    logic [63:0] ref_mem [RAM_DEPTH];
    logic        line_valid [LINE_COUNT];
    logic [63:0] line_tag [LINE_COUNT];
    logic [63:0] exp_rdata, exp_pb_adr, exp_pb_wdata, pb_data_q;
    logic [7:0]  exp_sel;
    logic [2:0]  exp_off;
    logic [1:0]  exp_size;
    logic        exp_dev;
    logic        exp_we;
    int          exp_lat, stb_age, wait_left, cycles;
    logic [63:0] dev_base [5];

    tb_clock #(.PERIOD(40ns)) u_clock (.clk(clk));

    mem_subsys_top #(
        .RAM_DEPTH_LOG2  (RAM_DEPTH_LOG2),
        .LINE_COUNT_LOG2 (LINE_COUNT_LOG2)
    ) dut (.*);

    function automatic logic [2:0] aligned_off(input logic [1:0] size, input logic [63:0] adr);
        return adr[2:0] & ~3'((1 << size) - 1);
    endfunction

    function automatic logic [63:0] width_mask(input logic [1:0] size);
        return (size == 2'd3) ? '1 : ((64'd1 << (8 << size)) - 1);
    endfunction

    // right-justified, zero-extended load from a 64-bit word.
    function automatic logic [63:0] pick(input logic [1:0] size, input logic [2:0] off,
                                         input logic [63:0] word);
        return (word >> (8 * off)) & width_mask(size);
    endfunction

    task automatic fail_stop();
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic access(input logic we, input logic [63:0] adr, input logic [1:0] size,
                          input logic [63:0] wdata, input logic dev);
        logic [2:0]  off;
        logic [63:0] idx, line, tag;
        off  = aligned_off(size, adr);
        idx  = (adr >> 3) % RAM_DEPTH;
        line = (adr >> 3) % LINE_COUNT;
        tag  = (adr >> 3) / LINE_COUNT;
        exp_lat <= 1;
        if (!dev && !we) begin
            exp_rdata <= pick(size, off, ref_mem[idx]);
            if (!(line_valid[line] && line_tag[line] == tag)) begin
                exp_lat          <= 3;  // ram read, fill, reply.
                line_valid[line]  = 1'b1;
                line_tag[line]    = tag;
            end
        end
        if (!dev && we) begin
            for (int b = 0; b < (1 << size); b++) begin
                ref_mem[idx][8 * (off + b) +: 8] = wdata[8 * b +: 8];
            end
        end
        exp_dev      <= dev;
        exp_we       <= we;
        exp_size     <= size;
        exp_off      <= off;
        exp_sel      <= 8'((1 << (1 << size)) - 1) << off;
        exp_pb_adr   <= adr & ~64'd7;
        exp_pb_wdata <= (wdata & width_mask(size)) << (8 * off);
        core_cyc     <= 1'b1;
        core_stb     <= 1'b1;
        core_we      <= we;
        core_adr     <= adr;
        core_size    <= mem_pkg::access_size_e'({1'b0, size});
        core_wdata   <= wdata;
        @(posedge clk);
        while (!core_ack) begin
            @(posedge clk);
        end
    endtask

    function automatic logic [63:0] cached_adr(input int word);
        return 64'h8000_0000 + 64'(word * 8) + 64'($urandom % 8);
    endfunction

    // peripheral answers after 0 to 3 random wait cycles.
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pb_ack    <= 1'b0;
            wait_left <= 0;
        end else begin
            pb_ack <= 1'b0;
            if (pb_cyc && pb_stb && !pb_ack) begin
                if (wait_left == 0) begin
                    pb_ack    <= 1'b1;
                    pb_rdata  <= {$urandom, $urandom};
                    wait_left <= $urandom % 4;
                end else begin
                    wait_left <= wait_left - 1;
                end
            end
            if (pb_cyc && pb_ack) begin
                pb_data_q <= pb_rdata;
            end
        end
    end

    always @(posedge clk) begin
        stb_age <= (core_stb && !core_ack) ? stb_age + 1 : 0;
        cycles  <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            fail_stop();
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> (!core_ack && !pb_cyc))
        else begin
            $display("ack or pb_cyc active during reset");
            fail_stop();
        end
    a_ack_stb: assert property (@(posedge clk) disable iff (!arst_n) core_ack |-> core_stb)
        else begin
            $display("core_ack seen without a strobe");
            fail_stop();
        end
    a_cache_rdata: assert property (@(posedge clk) disable iff (!arst_n)
        (core_ack && !exp_dev && !core_we) |-> core_rdata == exp_rdata)
        else begin
            $display("ERR t=%0t core_rdata exp=%h got=%h", $time, exp_rdata, core_rdata);
            fail_stop();
        end
    a_cache_lat: assert property (@(posedge clk) disable iff (!arst_n)
        (core_ack && !exp_dev) |-> stb_age == exp_lat)
        else begin
            $display("ERR t=%0t ack_latency exp=%0d got=%0d", $time, exp_lat, stb_age);
            fail_stop();
        end
    a_no_pb_cached: assert property (@(posedge clk) disable iff (!arst_n)
        (pb_cyc || pb_stb) |-> exp_dev)
        else begin
            $display("pb cycle raised for a cached access");
            fail_stop();
        end
    a_pb_adr: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(pb_stb) |-> pb_adr == exp_pb_adr)
        else begin
            $display("ERR t=%0t pb_adr exp=%h got=%h", $time, exp_pb_adr, pb_adr);
            fail_stop();
        end
    a_pb_sel: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(pb_stb) |-> pb_sel == exp_sel)
        else begin
            $display("ERR t=%0t pb_sel exp=%h got=%h", $time, exp_sel, pb_sel);
            fail_stop();
        end
    a_pb_we: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(pb_stb) |-> pb_we == exp_we)
        else begin
            $display("ERR t=%0t pb_we exp=%b got=%b", $time, exp_we, pb_we);
            fail_stop();
        end
    a_pb_wdata: assert property (@(posedge clk) disable iff (!arst_n)
        ($rose(pb_stb) && pb_we) |-> (pb_wdata & (width_mask(exp_size) << (8 * exp_off)))
                                     == exp_pb_wdata)
        else begin
            $display("ERR t=%0t pb_wdata exp=%h got=%h", $time, exp_pb_wdata, pb_wdata);
            fail_stop();
        end
    a_dev_ack: assert property (@(posedge clk) disable iff (!arst_n) pb_ack |=> core_ack)
        else begin
            $display("core_ack did not follow pb_ack by one cycle");
            fail_stop();
        end
    a_dev_rdata: assert property (@(posedge clk) disable iff (!arst_n)
        (core_ack && exp_dev && !core_we) |-> core_rdata == pick(exp_size, exp_off, pb_data_q))
        else begin
            $display("ERR t=%0t core_rdata exp=%h got=%h", $time,
                     pick(exp_size, exp_off, pb_data_q), core_rdata);
            fail_stop();
        end

    initial begin
        logic [63:0] a, b;
        void'($urandom(71));
        dev_base = '{64'h0200_0000, 64'h1000_0000, 64'h1000_1000, 64'h3000_0000, 64'h4000_0000};
        arst_n = 1'b0;
        cycles = 0;
        stb_age = 0;
        {core_cyc, core_stb, core_we} = '0;
        core_adr = '0;
        core_size = mem_pkg::SZ_BYTE;
        core_wdata = '0;
        pb_rdata = '0;
        pb_ack = 1'b0;
        pb_data_q = '0;
        exp_dev = 1'b0;
        exp_we = 1'b0;
        foreach (line_valid[i]) line_valid[i] = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        for (int w = 0; w < 64; w++) begin
            access(1'b1, 64'h8000_0000 + 64'(w * 8), 2'd3, {$urandom, $urandom}, 1'b0);
        end
        for (int i = 0; i < 150; i++) begin
            access(1'($urandom % 2), cached_adr($urandom % 64), 2'($urandom % 4),
                   {$urandom, $urandom}, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            a = 64'h8000_0000 + 64'(($urandom % 64) * 8);
            for (int k = 0; k < 4; k++) begin
                access(1'b1, a + 64'($urandom % 8), 2'($urandom % 2), {$urandom, $urandom},
                       1'b0);
            end
            access(1'b0, a, 2'd3, '0, 1'b0);
        end
        for (int i = 0; i < 10; i++) begin
            a = cached_adr($urandom % 16);
            b = a + 64'(LINE_COUNT * 8);  // same line, other tag.
            access(1'b0, a, 2'd3, '0, 1'b0);
            access(1'b0, b, 2'd3, '0, 1'b0);
            access(1'b0, b, 2'($urandom % 4), '0, 1'b0);
            access(1'b0, a, 2'($urandom % 4), '0, 1'b0);
        end
        for (int i = 0; i < 120; i++) begin
            access(1'($urandom % 2), dev_base[i % 5] + 64'($urandom % 256), 2'($urandom % 4),
                   {$urandom, $urandom}, 1'b1);
        end
        core_stb <= 1'b0;
        core_cyc <= 1'b0;
        repeat (4) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
hdl/mem_pkg.sv
hdl/mem_req_if.sv
hdl/uncache_router.sv
hdl/dcache_lite.sv
hdl/mmio_bridge.sv
hdl/mem_subsys_top.sv
test/tb_clock.sv
test/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# Compile with Verilator and run; the exit status carries pass or fail.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_top -o sim_tb \
    && ./obj_dir/sim_tb \
    || exit 1
